/* lotrPatterns.txt */
# mask wr1 addr1 wr2 addr2 data1 data2 exp1 err1 exp2 err2, all hex
# mask bit0 host1, bit1 host2, bit2 extra strobe while busy; ffffffff = lfsr word / model word
1 0 03000000 0 00000000 00000000 00000000 00000000 0 00000000 0
2 0 00000000 0 0300003f 00000000 00000000 00000000 0 00000000 0
3 0 03000011 0 03000022 00000000 00000000 00000000 0 00000000 0
1 1 03000005 0 00000000 12345678 00000000 12345678 0 00000000 0
1 0 03000005 0 00000000 00000000 00000000 12345678 0 00000000 0
2 0 00000000 1 0300003f 00000000 a5a5c3c3 00000000 0 a5a5c3c3 0
2 0 00000000 0 0300003f 00000000 00000000 00000000 0 a5a5c3c3 0
1 1 03000010 0 00000000 ffffffff 00000000 ffffffff 0 00000000 0
1 0 03000010 0 00000000 00000000 00000000 ffffffff 0 00000000 0
1 1 03000011 0 00000000 ffffffff 00000000 ffffffff 0 00000000 0
1 0 03000011 0 00000000 00000000 00000000 ffffffff 0 00000000 0
1 1 03000012 0 00000000 ffffffff 00000000 ffffffff 0 00000000 0
1 0 03000012 0 00000000 00000000 00000000 ffffffff 0 00000000 0
2 0 00000000 1 0300002a 00000000 ffffffff 00000000 0 ffffffff 0
2 0 00000000 0 0300002a 00000000 00000000 00000000 0 ffffffff 0
2 0 00000000 1 0300002b 00000000 ffffffff 00000000 0 ffffffff 0
2 0 00000000 0 0300002b 00000000 00000000 00000000 0 ffffffff 0
3 1 03000020 1 03000021 ffffffff ffffffff ffffffff 0 ffffffff 0
3 0 03000021 0 03000020 00000000 00000000 ffffffff 0 ffffffff 0
3 1 03000030 1 03000031 ffffffff ffffffff ffffffff 0 ffffffff 0
3 0 03000031 0 03000030 00000000 00000000 ffffffff 0 ffffffff 0
1 0 07000010 0 00000000 00000000 00000000 00000000 1 00000000 0
2 0 00000000 0 00000004 00000000 00000000 00000000 0 00000000 1
1 1 ff000008 0 00000000 deadbeef 00000000 00000000 1 00000000 0
1 0 03000008 0 00000000 00000000 00000000 00000000 0 00000000 0
3 0 07000010 0 03000005 00000000 00000000 00000000 1 12345678 0
5 1 03000018 0 00000000 ffffffff 00000000 ffffffff 0 00000000 0
2 0 00000000 0 03000018 00000000 00000000 00000000 0 ffffffff 0
6 0 00000000 0 03000005 00000000 00000000 00000000 0 12345678 0
1 0 03000005 0 00000000 00000000 00000000 12345678 0 00000000 0
7 1 0300001a 1 0300001b ffffffff ffffffff ffffffff 0 ffffffff 0
3 0 0300001b 0 0300001a 00000000 00000000 ffffffff 0 ffffffff 0

/* lotr.f */
+incdir+.
ringPkg.sv
tilePkg.sv
ringIf.sv
ringController.sv
hostTile.sv
memTile.sv
lotr.sv
tbLotr.sv

/* runSim.sh */
#!/usr/bin/env bash
# build and run the LOTR ring testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert -f lotr.f --top-module tbLotr -Mdir "$BUILD" -o VtbLotr
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/VtbLotr" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "All tests passed!" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* tbLotr.sv */
/*
 * LOTR ring testbench
 */
`timescale 1ns/10ps
`default_nettype none
`include "lotr_consts.svh"

module tbLotr;

    localparam int          RSP_TIMEOUT  = 200;    // cycles per step
    localparam int          QUIET_CYCLES = 8;      // watch for stray responses
    localparam logic [31:0] MARKER       = 32'hffffffff;

    logic               QClk;
    logic               rstN;
    logic [1:0]         cmdValid;       // bit 0 host 1, bit 1 host 2
    logic [1:0]         cmdWrite;
    ringPkg::tAddr      cmdAddr [2];
    ringPkg::tData      cmdData [2];
    logic [1:0]         cmdBusy;
    logic [1:0]         rspValid;
    logic [1:0]         rspError;
    ringPkg::tData      rspData [2];

    // scoreboard
    logic [1:0]         pending;        // response still owed
    ringPkg::tData      expData [2];
    logic [1:0]         expErr;
    ringPkg::tData      model [`LOTR_MEM_DEPTH];   // mirror of the memory tile
    logic [15:0]        lfsr;

    // current pattern line
    logic [31:0]        stepMask;
    logic [31:0]        stepWr [2];
    logic [31:0]        stepAddr [2];
    logic [31:0]        stepData [2];
    logic [31:0]        stepExp [2];
    logic [31:0]        stepErr [2];

    lotr UUT (
        .QClk       (QClk),
        .rstN       (rstN),
        .h1CmdValid (cmdValid[0]),
        .h1CmdWrite (cmdWrite[0]),
        .h1CmdAddr  (cmdAddr[0]),
        .h1CmdData  (cmdData[0]),
        .h1CmdBusy  (cmdBusy[0]),
        .h1RspValid (rspValid[0]),
        .h1RspError (rspError[0]),
        .h1RspData  (rspData[0]),
        .h2CmdValid (cmdValid[1]),
        .h2CmdWrite (cmdWrite[1]),
        .h2CmdAddr  (cmdAddr[1]),
        .h2CmdData  (cmdData[1]),
        .h2CmdBusy  (cmdBusy[1]),
        .h2RspValid (rspValid[1]),
        .h2RspError (rspError[1]),
        .h2RspData  (rspData[1])
    );

    initial begin
        QClk = 1'b0;
        forever #5 QClk = ~QClk;   // 10 ns
    end

    // ==============================
    // helpers
    // ==============================
    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawWord(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsrNext(lfsr);     // one step per bit
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    // one falling edge, then score any response pulse
    task automatic tickSample();
        @(negedge QClk);
        for (int h = 0; h < 2; h++) begin
            if (rspValid[h]) begin
                assert (pending[h]) else
                    stopOnError($sformatf("ERR %0t: host%0d rspValid with nothing pending",
                                          $time, h + 1));
                assert (rspData[h] === expData[h] && rspError[h] === expErr[h]) else
                    stopOnError($sformatf("ERR %0t: host%0d data %h err %b, expected %h err %b",
                                          $time, h + 1, rspData[h], rspError[h],
                                          expData[h], expErr[h]));
                pending[h] = 1'b0;
            end
        end
    endtask

    // ==============================
    // one pattern line
    // ==============================
    task automatic runStep(input logic [31:0] mask);
        logic [`LOTR_MEM_AW-1:0] idx;
        int                      waitCnt;
        ringPkg::tData           wdata [2];

        // resolve data, writes land in the model unless they bounce
        for (int h = 0; h < 2; h++) begin
            wdata[h] = stepData[h];
            if (mask[h]) begin
                idx = stepAddr[h][`LOTR_MEM_AW-1:0];
                if (stepData[h] == MARKER) drawWord(wdata[h]);
                if (stepWr[h][0] && !stepErr[h][0]) model[idx] = wdata[h];
            end
        end
        for (int h = 0; h < 2; h++) begin
            if (mask[h]) begin
                idx         = stepAddr[h][`LOTR_MEM_AW-1:0];
                expData[h]  = (stepExp[h] == MARKER) ? model[idx] : stepExp[h];
                expErr[h]   = stepErr[h][0];
                pending[h]  = 1'b1;
                cmdValid[h] = 1'b1;
                cmdWrite[h] = stepWr[h][0];
                cmdAddr[h]  = stepAddr[h];
                cmdData[h]  = wdata[h];
            end
        end
        tickSample();

        // command latched, host busy
        for (int h = 0; h < 2; h++) begin
            if (mask[h]) begin
                assert (cmdBusy[h]) else
                    stopOnError($sformatf("ERR %0t: host%0d cmdBusy low after command",
                                          $time, h + 1));
            end
        end
        cmdValid = '0;

        // extra write strobe while the request is in flight
        if (mask[2]) begin
            tickSample();
            for (int h = 0; h < 2; h++) begin
                if (mask[h]) begin
                    assert (cmdBusy[h]) else
                        stopOnError($sformatf("ERR %0t: host%0d not busy at extra strobe",
                                              $time, h + 1));
                    cmdValid[h] = 1'b1;
                    cmdWrite[h] = 1'b1;
                    cmdData[h]  = ~wdata[h];
                end
            end
            tickSample();
            cmdValid = '0;
        end

        waitCnt = 0;
        while (pending != 2'b00 && waitCnt < RSP_TIMEOUT) begin
            tickSample();
            waitCnt++;
        end
        assert (pending == 2'b00) else
            stopOnError($sformatf("no response within %0d cycles, stopped at %0t",
                                  RSP_TIMEOUT, $time));

        repeat (QUIET_CYCLES) tickSample();  // exactly one pulse per command
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        int    fd;
        int    n;
        int    lineNo;
        int    steps;
        string line;

        rstN     = 1'b0;
        cmdValid = '0;
        cmdWrite = '0;
        for (int h = 0; h < 2; h++) begin
            cmdAddr[h] = '0;
            cmdData[h] = '0;
            expData[h] = '0;
        end
        expErr  = '0;
        pending = '0;
        lfsr    = 16'd11861;
        for (int i = 0; i < `LOTR_MEM_DEPTH; i++) model[i] = '0;
        lineNo = 0;
        steps  = 0;

        repeat (5) @(negedge QClk);
        rstN = 1'b1;
        assert (cmdBusy == 2'b00 && rspValid == 2'b00) else
            stopOnError($sformatf("ERR %0t: busy %b rspValid %b after reset",
                                  $time, cmdBusy, rspValid));
        repeat (20) tickSample();   // idle ring, nothing may answer

        fd = $fopen("lotrPatterns.txt", "r");
        assert (fd != 0) else stopOnError("cannot open the pattern file lotrPatterns.txt");

        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            lineNo++;
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", stepMask,
                            stepWr[0], stepAddr[0], stepWr[1], stepAddr[1],
                            stepData[0], stepData[1], stepExp[0], stepErr[0],
                            stepExp[1], stepErr[1]);
                assert (n == 11) else
                    stopOnError($sformatf("pattern line %0d does not hold 11 fields", lineNo));
                runStep(stepMask);
                steps++;
            end
        end
        $fclose(fd);
        assert (steps > 0) else stopOnError("the pattern file holds no steps");

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* lotr.sv */
/*
 * LOTR ring top
 */
`timescale 1ns/10ps
`default_nettype none
`include "lotr_consts.svh"

module lotr (
    input  logic          QClk,
    input  logic          rstN,
    // ==============================
    // host 1 command port
    // ==============================
    input  logic          h1CmdValid,
    input  logic          h1CmdWrite,
    input  ringPkg::tAddr h1CmdAddr,
    input  ringPkg::tData h1CmdData,
    output logic          h1CmdBusy,
    output logic          h1RspValid,
    output logic          h1RspError,
    output ringPkg::tData h1RspData,
    // ==============================
    // host 2 command port
    // ==============================
    input  logic          h2CmdValid,
    input  logic          h2CmdWrite,
    input  ringPkg::tAddr h2CmdAddr,
    input  ringPkg::tData h2CmdData,
    output logic          h2CmdBusy,
    output logic          h2RspValid,
    output logic          h2RspError,
    output ringPkg::tData h2RspData
);

    // hop i feeds tile i+1, last tile closes the ring into hop 0
    ringIf reqHop [`LOTR_NUM_TILE] ();
    ringIf rspHop [`LOTR_NUM_TILE] ();

    // tile 1
    hostTile #(.CORE_ID(`LOTR_HOST1_ID)) host1 (
        .QClk     (QClk),
        .rstN     (rstN),
        .cmdValid (h1CmdValid),
        .cmdWrite (h1CmdWrite),
        .cmdAddr  (h1CmdAddr),
        .cmdData  (h1CmdData),
        .cmdBusy  (h1CmdBusy),
        .rspValid (h1RspValid),
        .rspError (h1RspError),
        .rspData  (h1RspData),
        .reqIn    (reqHop[0]),
        .rspIn    (rspHop[0]),
        .reqOut   (reqHop[1]),
        .rspOut   (rspHop[1])
    );

    // tile 2
    hostTile #(.CORE_ID(`LOTR_HOST2_ID)) host2 (
        .QClk     (QClk),
        .rstN     (rstN),
        .cmdValid (h2CmdValid),
        .cmdWrite (h2CmdWrite),
        .cmdAddr  (h2CmdAddr),
        .cmdData  (h2CmdData),
        .cmdBusy  (h2CmdBusy),
        .rspValid (h2RspValid),
        .rspError (h2RspError),
        .rspData  (h2RspData),
        .reqIn    (reqHop[1]),
        .rspIn    (rspHop[1]),
        .reqOut   (reqHop[2]),
        .rspOut   (rspHop[2])
    );

    // tile 3, output wraps back to host 1
    memTile mem3 (
        .QClk   (QClk),
        .rstN   (rstN),
        .reqIn  (reqHop[2]),
        .rspIn  (rspHop[2]),
        .reqOut (reqHop[0]),
        .rspOut (rspHop[0])
    );

endmodule

`default_nettype wire

/* memTile.sv */
/*
 * LOTR memory tile
 */
`timescale 1ns/10ps
`default_nettype none
`include "lotr_consts.svh"

module memTile (
    input  logic QClk,
    input  logic rstN,
    ringIf.dst   reqIn,
    ringIf.dst   rspIn,
    ringIf.src   reqOut,
    ringIf.src   rspOut
);

    tilePkg::tMemState      state;
    ringPkg::tData          mem [`LOTR_MEM_DEPTH];
    logic [`LOTR_MEM_AW-1:0] memIdx;
    logic                   ejReqValid;
    ringPkg::tRequestor     ejReqRequestor;
    ringPkg::tOpcode        ejReqOpcode;
    ringPkg::tAddr          ejReqAddr;
    ringPkg::tData          ejReqData;
    logic                   locRspValid;
    logic                   locRspTaken;
    ringPkg::tOpcode        rspOpcode;      // pending response
    ringPkg::tRequestor     rspRequestor;
    ringPkg::tAddr          rspAddr;
    ringPkg::tData          rspData;

    assign memIdx      = ejReqAddr[`LOTR_MEM_AW-1:0];
    assign locRspValid = (state == tilePkg::RESPOND);

    // ==============================
    // responder FSM
    // ==============================
    // no response passes this tile, so the slot is granted at once
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            state <= tilePkg::MEM_IDLE;
        end else begin
            case (state)
                tilePkg::MEM_IDLE: if (ejReqValid) state <= tilePkg::RESPOND;
                tilePkg::RESPOND: begin
                    if (locRspTaken && !ejReqValid) state <= tilePkg::MEM_IDLE;
                end
                default: state <= tilePkg::MEM_IDLE;
            endcase
        end
    end

    // ram and response build
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            for (int i = 0; i < `LOTR_MEM_DEPTH; i++) begin
                mem[i] <= '0;       // reads before writes return zero
            end
        end else if (ejReqValid) begin
            rspRequestor <= ejReqRequestor;     // answer goes back to originator
            rspAddr      <= ejReqAddr;
            case (ejReqOpcode)
                ringPkg::RD: begin
                    rspOpcode <= ringPkg::RD_RSP;
                    rspData   <= mem[memIdx];
                end
                ringPkg::WR: begin
                    mem[memIdx] <= ejReqData;
                    rspOpcode   <= ringPkg::WR_RSP;
                    rspData     <= ejReqData;   // echo
                end
                default: begin
                    rspOpcode <= ringPkg::ERR_RSP;  // not a request
                    rspData   <= '0;
                end
            endcase
        end
    end

    ringController rc (
        .QClk(QClk), .rstN(rstN), .CoreID(`LOTR_MEM_ID),
        .reqIn(reqIn), .rspIn(rspIn), .reqOut(reqOut), .rspOut(rspOut),
        .locReqValid(1'b0), .locReqOpcode(ringPkg::RD),   // memory never originates
        .locReqAddr('0), .locReqData('0),
        .locRspValid(locRspValid), .locRspOpcode(rspOpcode),
        .locRspRequestor(rspRequestor), .locRspAddr(rspAddr), .locRspData(rspData),
        .locReqTaken(), .locRspTaken(locRspTaken),
        .ejReqValid(ejReqValid), .ejReqRequestor(ejReqRequestor),
        .ejReqOpcode(ejReqOpcode), .ejReqAddr(ejReqAddr), .ejReqData(ejReqData),
        .ejRspValid(), .ejRspOpcode(), .ejRspData()
    );

endmodule

`default_nettype wire

/* hostTile.sv */
/*
 * LOTR host tile
 */
`timescale 1ns/10ps
`default_nettype none
`include "lotr_consts.svh"

module hostTile #(
    parameter ringPkg::tRequestor CORE_ID = `LOTR_HOST1_ID
) (
    input  logic          QClk,
    input  logic          rstN,
    input  logic          cmdValid,     // one cycle strobe
    input  logic          cmdWrite,
    input  ringPkg::tAddr cmdAddr,
    input  ringPkg::tData cmdData,
    output logic          cmdBusy,
    output logic          rspValid,     // one cycle pulse
    output logic          rspError,
    output ringPkg::tData rspData,
    ringIf.dst            reqIn,
    ringIf.dst            rspIn,
    ringIf.src            reqOut,
    ringIf.src            rspOut
);

    tilePkg::tHostState state;
    ringPkg::tOpcode    reqOpcode;      // latched command
    ringPkg::tAddr      reqAddr;
    ringPkg::tData      reqData;
    logic               locReqValid;
    logic               locReqTaken;
    logic               ejReqValid;
    ringPkg::tRequestor ejReqRequestor;
    logic               ejRspValid;
    ringPkg::tOpcode    ejRspOpcode;
    ringPkg::tData      ejRspData;
    logic               bounced;

    assign cmdBusy     = (state != tilePkg::HOST_IDLE);
    assign locReqValid = (state == tilePkg::ISSUE);

    // own request came all the way round, nobody claimed it
    assign bounced = ejReqValid && (ejReqRequestor == CORE_ID);

    // ==============================
    // command FSM
    // ==============================
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            state    <= tilePkg::HOST_IDLE;
            rspValid <= 1'b0;
        end else begin
            rspValid <= 1'b0;
            case (state)
                tilePkg::HOST_IDLE: if (cmdValid) state <= tilePkg::ISSUE;
                tilePkg::ISSUE:     if (locReqTaken) state <= tilePkg::WAIT_RSP;
                tilePkg::WAIT_RSP: begin
                    if (ejRspValid || bounced) begin
                        state    <= tilePkg::HOST_IDLE;
                        rspValid <= 1'b1;
                    end
                end
                default: state <= tilePkg::HOST_IDLE;
            endcase
        end
    end

    // payload regs
    always_ff @(posedge QClk) begin
        if (state == tilePkg::HOST_IDLE && cmdValid) begin
            reqOpcode <= cmdWrite ? ringPkg::WR : ringPkg::RD;
            reqAddr   <= cmdAddr;
            reqData   <= cmdData;
        end
        if (ejRspValid) begin
            rspData  <= ejRspData;
            rspError <= (ejRspOpcode == ringPkg::ERR_RSP);
        end else if (bounced) begin
            rspData  <= '0;
            rspError <= 1'b1;   // unclaimed
        end
    end

    ringController rc (
        .QClk(QClk), .rstN(rstN), .CoreID(CORE_ID),
        .reqIn(reqIn), .rspIn(rspIn), .reqOut(reqOut), .rspOut(rspOut),
        .locReqValid(locReqValid), .locReqOpcode(reqOpcode),
        .locReqAddr(reqAddr), .locReqData(reqData),
        .locRspValid(1'b0), .locRspOpcode(ringPkg::ERR_RSP),   // hosts never answer
        .locRspRequestor('0), .locRspAddr('0), .locRspData('0),
        .locReqTaken(locReqTaken), .locRspTaken(),
        .ejReqValid(ejReqValid), .ejReqRequestor(ejReqRequestor),
        .ejReqOpcode(), .ejReqAddr(), .ejReqData(),
        .ejRspValid(ejRspValid), .ejRspOpcode(ejRspOpcode), .ejRspData(ejRspData)
    );

endmodule

`default_nettype wire

/* ringController.sv */
/*
 * LOTR ring controller
 */
`timescale 1ns/10ps
`default_nettype none
`include "lotr_consts.svh"

module ringController (
    input  logic               QClk,
    input  logic               rstN,
    input  ringPkg::tRequestor CoreID,
    ringIf.dst                 reqIn,
    ringIf.dst                 rspIn,
    ringIf.src                 reqOut,
    ringIf.src                 rspOut,
    // tile -> ring, held until taken
    input  logic               locReqValid,
    input  ringPkg::tOpcode    locReqOpcode,
    input  ringPkg::tAddr      locReqAddr,
    input  ringPkg::tData      locReqData,
    input  logic               locRspValid,
    input  ringPkg::tOpcode    locRspOpcode,
    input  ringPkg::tRequestor locRspRequestor,
    input  ringPkg::tAddr      locRspAddr,
    input  ringPkg::tData      locRspData,
    output logic               locReqTaken,     // slot grant
    output logic               locRspTaken,
    // ring -> tile, one cycle pulses
    output logic               ejReqValid,
    output ringPkg::tRequestor ejReqRequestor,
    output ringPkg::tOpcode    ejReqOpcode,
    output ringPkg::tAddr      ejReqAddr,
    output ringPkg::tData      ejReqData,
    output logic               ejRspValid,
    output ringPkg::tOpcode    ejRspOpcode,
    output ringPkg::tData      ejRspData
);

    logic reqEject;
    logic reqPass;
    logic rspEject;
    logic rspPass;

    // ==============================
    // slot decode
    // ==============================

    // addressed to us, or our own request back unclaimed
    assign reqEject = reqIn.valid &&
                      ((reqIn.address[`LOTR_TARGET_MSB:`LOTR_TARGET_LSB] == CoreID) ||
                       (reqIn.requestor == CoreID));
    assign reqPass  = reqIn.valid && !reqEject;

    assign rspEject = rspIn.valid && (rspIn.requestor == CoreID);
    assign rspPass  = rspIn.valid && !rspEject;

    // passing traffic wins, local fills a free or ejected slot
    assign locReqTaken = locReqValid && !reqPass;
    assign locRspTaken = locRspValid && !rspPass;

    // ==============================
    // registered hop outputs
    // ==============================
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            reqOut.valid <= 1'b0;
            rspOut.valid <= 1'b0;
            ejReqValid   <= 1'b0;
            ejRspValid   <= 1'b0;
        end else begin
            reqOut.valid <= reqPass || locReqTaken;
            rspOut.valid <= rspPass || locRspTaken;
            ejReqValid   <= reqEject;
            ejRspValid   <= rspEject;
        end
    end

    // message fields, qualified by the valids above
    always_ff @(posedge QClk) begin
        if (reqPass) begin
            reqOut.requestor <= reqIn.requestor;    // forward as is
            reqOut.opcode    <= reqIn.opcode;
            reqOut.address   <= reqIn.address;
            reqOut.data      <= reqIn.data;
        end else begin
            reqOut.requestor <= CoreID;             // local request carries our id
            reqOut.opcode    <= locReqOpcode;
            reqOut.address   <= locReqAddr;
            reqOut.data      <= locReqData;
        end

        if (rspPass) begin
            rspOut.requestor <= rspIn.requestor;
            rspOut.opcode    <= rspIn.opcode;
            rspOut.address   <= rspIn.address;
            rspOut.data      <= rspIn.data;
        end else begin
            rspOut.requestor <= locRspRequestor;    // route back to originator
            rspOut.opcode    <= locRspOpcode;
            rspOut.address   <= locRspAddr;
            rspOut.data      <= locRspData;
        end

        // ejected copies for the tile
        ejReqRequestor <= reqIn.requestor;
        ejReqOpcode    <= reqIn.opcode;
        ejReqAddr      <= reqIn.address;
        ejReqData      <= reqIn.data;
        ejRspOpcode    <= rspIn.opcode;
        ejRspData      <= rspIn.data;
    end

endmodule

`default_nettype wire

/* ringIf.sv */
/*
 * LOTR ring hop
 */
`timescale 1ns/10ps
`default_nettype none

// one registered hop between two ring controllers
interface ringIf;

    logic               valid;      // slot occupied
    ringPkg::tRequestor requestor;
    ringPkg::tOpcode    opcode;
    ringPkg::tAddr      address;
    ringPkg::tData      data;

    // upstream controller drives the hop
    modport src (
        output valid, requestor, opcode, address, data
    );

    // downstream controller samples it
    modport dst (
        input valid, requestor, opcode, address, data
    );

endinterface

`default_nettype wire

/* tilePkg.sv */
/*
 * LOTR tile state machines
 */
`default_nettype none

package tilePkg;

    // host command port, one request in flight
    typedef enum logic [1:0] {
        HOST_IDLE,      // ready for a command
        ISSUE,          // waiting for a free request slot
        WAIT_RSP        // request on the ring
    } tHostState;

    // memory responder
    typedef enum logic {
        MEM_IDLE,
        RESPOND         // response offered to the controller
    } tMemState;

endpackage

`default_nettype wire

/* ringPkg.sv */
/*
 * LOTR ring message types
 */
`default_nettype none

package ringPkg;

    // ==============================
    // message fields
    // ==============================

    // request and response opcodes share one field
    typedef enum logic [2:0] {
        RD      = 3'd0,     // read request
        WR      = 3'd1,     // write request
        RD_RSP  = 3'd2,     // read data back
        WR_RSP  = 3'd3,     // write ack
        ERR_RSP = 3'd4      // target could not serve
    } tOpcode;

    // originator core id, also the response destination
    typedef logic [7:0]  tRequestor;

    // [31:24] target core id, low bits word offset
    typedef logic [31:0] tAddr;

    // payload word
    typedef logic [31:0] tData;

endpackage

`default_nettype wire

/* lotr_consts.svh */
/*
 * LOTR ring constants
 */
`ifndef LOTR_CONSTS_SVH
`define LOTR_CONSTS_SVH

// ==============================
// ring topology
// ==============================
`define LOTR_NUM_TILE   3       // tiles on each ring

// core ids, ring order host1 -> host2 -> mem
`define LOTR_HOST1_ID   8'd1
`define LOTR_HOST2_ID   8'd2
`define LOTR_MEM_ID     8'd3

// ==============================
// memory tile
// ==============================
`define LOTR_MEM_DEPTH  64      // words
`define LOTR_MEM_AW     6       // low address bits index the ram

// target core id lives in the top byte of the address
`define LOTR_TARGET_MSB 31
`define LOTR_TARGET_LSB 24

`endif
